// ==== lc3b_pipe.f ====
src/lc3b_types.sv
src/decode.sv
src/stage_queue.sv
src/alu.sv
src/execute.sv
src/lc3b_pipe.sv
testbench/lc3b_pipe_tb.sv

// ==== Makefile ====
SIM := obj_dir/lc3b_pipe_tb
SRCS := $(shell cat lc3b_pipe.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): lc3b_pipe.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module lc3b_pipe_tb \
		-f lc3b_pipe.f -o lc3b_pipe_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== testbench/lc3b_pipe_tb.sv ====
module lc3b_pipe_tb;

import lc3b_types::*;

localparam int clk_period = 8;
localparam int stall_margin = 6;
localparam int n_alu = 60;
localparam int n_addr = 60;
localparam int n_branch = 80;
localparam int n_stress = 160;
localparam int total_instr = 1 + n_alu + n_addr + n_branch + n_stress;
localparam int reset_time = 3 * clk_period;
localparam int watchdog_time = total_instr * clk_period * stall_margin + reset_time;

localparam int group_alu = 0;
localparam int group_addr = 1;
localparam int group_branch = 2;
localparam int group_all = 3;

logic clk = 1'b0;
logic reset;
logic fetch_valid;
fetch_packet fetch;
logic mem_stall;
logic fetch_stall;
logic mem_valid;
mem_packet mem;

int seed;
string current_test;
logic stall_enable;
int stall_left;
logic stall_seen;

int main_checks;
int main_errors;
int mon_checks;
int mon_errors;
int checks_at_start;
int errors_at_start;
int tests_run;

lc3b_nzp model_cc;
mem_packet exp_q [$];
mem_packet expected;
mem_packet held_mem;
logic hold_pending;

lc3b_pipe lc3b_pipe_inst
(
    .clk,
    .reset,
    .fetch_valid,
    .fetch,
    .mem_stall,
    .fetch_stall,
    .mem_valid,
    .mem
);

always #(clk_period / 2) clk = ~clk;

// the reference model runs in program order as instructions are taken.
function automatic mem_packet model_step(input fetch_packet f);
    mem_packet m;
    logic [15:0] iw;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] off6;
    logic [15:0] off9;
    logic [31:0] wide;
    logic [3:0] amt;
    logic set_cc;
    iw = f.instruction;
    a = f.sr1_val;
    b = f.sr2_val;
    imm = {{11{iw[4]}}, iw[4:0]};
    off6 = {{10{iw[5]}}, iw[5:0]};
    off9 = {{7{iw[8]}}, iw[8:0]};
    amt = iw[3:0];
    set_cc = 1'b0;
    m = '0;
    m.opcode = lc3b_opcode'(iw[15:12]);
    m.dr = iw[11:9];
    // loads, branches and jumps pass the register operand through.
    m.result = b;
    m.address = f.npc;
    case (m.opcode)
        op_add:
        begin
            m.result = a + (iw[5] ? imm : b);
            set_cc = 1'b1;
        end
        op_and:
        begin
            m.result = a & (iw[5] ? imm : b);
            set_cc = 1'b1;
        end
        op_not:
        begin
            m.result = ~a;
            set_cc = 1'b1;
        end
        op_shf:
        begin
            wide = {{16{a[15]}}, a} >> amt;
            if (!iw[4])
                m.result = a << amt;
            else if (iw[5])
                m.result = wide[15:0];
            else
                m.result = a >> amt;
            set_cc = 1'b1;
        end
        op_lea:
        begin
            m.address = f.npc + {off9[14:0], 1'b0};
            m.result = m.address;
            set_cc = 1'b1;
        end
        op_ldr:
        begin
            m.address = a + {off6[14:0], 1'b0};
            m.mem_read = 1'b1;
        end
        op_str:
        begin
            m.address = a + {off6[14:0], 1'b0};
            m.mem_write = 1'b1;
        end
        op_ldb:
        begin
            m.address = a + off6;
            m.mem_read = 1'b1;
            m.byte_access = 1'b1;
        end
        op_stb:
        begin
            m.address = a + off6;
            m.mem_write = 1'b1;
            m.byte_access = 1'b1;
        end
        op_br:
        begin
            m.address = f.npc + {off9[14:0], 1'b0};
            m.br_taken = (iw[11:9] & model_cc) != 3'b000;
        end
        op_jmp:
        begin
            m.address = a;
            m.br_taken = 1'b1;
        end
        default:
        begin
            m.result = b;
        end
    endcase
    if (set_cc)
        model_cc = m.result[15] ? 3'b100 : ((m.result == 16'h0000) ? 3'b010 : 3'b001);
    m.cc = model_cc;
    return m;
endfunction

function automatic lc3b_opcode pick_opcode(input int group, input logic [31:0] r);
    int sel;
    lc3b_opcode op;
    case (group)
        group_alu: sel = int'(r[15:0]) % 4;
        group_addr: sel = 4 + int'(r[15:0]) % 6;
        group_branch: sel = r[16] ? 10 : int'(r[15:0]) % 10;
        default: sel = int'(r[15:0]) % 11;
    endcase
    case (sel)
        0: op = op_add;
        1: op = op_and;
        2: op = op_not;
        3: op = op_shf;
        4: op = op_ldr;
        5: op = op_str;
        6: op = op_ldb;
        7: op = op_stb;
        8: op = op_lea;
        9: op = op_jmp;
        default: op = op_br;
    endcase
    return op;
endfunction

function automatic lc3b_word operand_value();
    logic [31:0] r;
    r = $random(seed);
    // zero and small values keep the zero condition code in play.
    if (r[2:0] == 3'd0)
        return 16'h0000;
    if (r[2:0] == 3'd1)
        return {12'h000, r[19:16]};
    return r[31:16];
endfunction

function automatic fetch_packet random_packet(input int group);
    fetch_packet p;
    lc3b_opcode op;
    logic [31:0] r;
    r = $random(seed);
    op = pick_opcode(group, r);
    p.instruction = lc3b_instr'({op, r[31:20]});
    r = $random(seed);
    p.npc = r[15:0];
    p.sr1_val = operand_value();
    p.sr2_val = operand_value();
    return p;
endfunction

function automatic int random_gap();
    logic [31:0] r;
    r = $random(seed);
    return (r[2:0] == 3'd0) ? int'(r[4:3]) + 1 : 0;
endfunction

task automatic drive_stall();
    logic [31:0] r;
    if (!stall_enable)
        mem_stall = 1'b0;
    else if (stall_left > 0)
    begin
        mem_stall = 1'b1;
        stall_left--;
    end
    else
    begin
        r = $random(seed);
        mem_stall = (r[1:0] == 2'd0);
        if (mem_stall)
            stall_left = int'(r[10:8]) % 5;
    end
endtask

// holds the packet until an edge takes it.
task automatic send_instr(input fetch_packet pkt, input int gap);
    logic taken;
    repeat (gap)
    begin
        @(negedge clk);
        fetch_valid = 1'b0;
        drive_stall();
    end
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch = pkt;
    drive_stall();
    taken = 1'b0;
    while (!taken)
    begin
        @(posedge clk);
        taken = !fetch_stall;
        if (!taken)
        begin
            @(negedge clk);
            drive_stall();
        end
    end
endtask

task automatic drain();
    @(negedge clk);
    fetch_valid = 1'b0;
    stall_enable = 1'b0;
    mem_stall = 1'b0;
    stall_left = 0;
    while (exp_q.size() != 0)
        @(negedge clk);
    repeat (3) @(negedge clk);
endtask

task automatic check_word(input string what, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    main_checks++;
    assert (act_val === exp_val)
    else
    begin
        main_errors++;
        $display("FAILED %s %s: expected %h, actual %h", current_test, what, exp_val, act_val);
    end
endtask

task automatic begin_test(input string name);
    current_test = name;
    checks_at_start = main_checks + mon_checks;
    errors_at_start = main_errors + mon_errors;
endtask

task automatic end_test();
    $display("%s: %0d checks, %0d errors", current_test,
             main_checks + mon_checks - checks_at_start,
             main_errors + mon_errors - errors_at_start);
    tests_run++;
endtask

task automatic run_reset_latency();
    fetch_packet p;
    logic [15:0] iw;
    int edges;
    begin_test("reset_latency");
    check_word("mem_valid after reset", 32'd0, 32'(mem_valid));
    check_word("fetch_stall after reset", 32'd0, 32'(fetch_stall));
    // a load leaves cc alone, so the first result shows the reset value.
    p = random_packet(group_addr);
    iw = p.instruction;
    p.instruction = lc3b_instr'({op_ldr, iw[11:0]});
    send_instr(p, 0);
    @(negedge clk);
    fetch_valid = 1'b0;
    edges = 0;
    while (!mem_valid && edges < 16)
    begin
        @(negedge clk);
        edges++;
    end
    main_checks++;
    assert (mem_valid)
    else
    begin
        main_errors++;
        $display("%s: no result appeared within 16 cycles of the taking edge", current_test);
    end
    check_word("latency in edges", 32'd2, 32'(edges));
    check_word("cc of first result", 32'h2, 32'(mem.cc));
    drain();
    end_test();
endtask

task automatic run_stream(input string name, input int group, input int count,
                          input logic stalls);
    fetch_packet p;
    int gap;
    begin_test(name);
    stall_enable = stalls;
    stall_left = 0;
    for (int i = 0; i < count; i++)
    begin
        p = random_packet(group);
        gap = random_gap();
        send_instr(p, gap);
    end
    drain();
    if (stalls)
    begin
        main_checks++;
        assert (stall_seen)
        else
        begin
            main_errors++;
            $display("%s: fetch_stall never rose under memory stalls", current_test);
        end
    end
    end_test();
endtask

// the monitor checks held output, compares results and then captures taken instructions.
always @(posedge clk)
begin
    if (reset)
    begin
        model_cc = 3'b010;
        exp_q.delete();
        hold_pending = 1'b0;
        stall_seen = 1'b0;
    end
    else
    begin
        if (hold_pending)
        begin
            mon_checks++;
            assert (mem_valid)
            else
            begin
                mon_errors++;
                $display("%s: mem_valid dropped while the memory stage stalled", current_test);
            end
            assert (mem === held_mem)
            else
            begin
                mon_errors++;
                $display("FAILED %s held output: expected %h, actual %h",
                         current_test, held_mem, mem);
            end
        end
        hold_pending = mem_valid && mem_stall;
        held_mem = mem;
        if (mem_valid && !mem_stall)
        begin
            mon_checks++;
            assert (exp_q.size() > 0)
            else
            begin
                mon_errors++;
                $display("%s: a result appeared with no instruction outstanding", current_test);
            end
            if (exp_q.size() > 0)
            begin
                expected = exp_q.pop_front();
                assert (mem === expected)
                else
                begin
                    mon_errors++;
                    $display("FAILED %s: expected %h, actual %h", current_test, expected, mem);
                end
            end
        end
        if (fetch_stall)
            stall_seen = 1'b1;
        if (fetch_valid && !fetch_stall)
            exp_q.push_back(model_step(fetch));
    end
end

initial
begin
    #(watchdog_time);
    $display("watchdog expired after %0d time units, the pipeline stopped producing results",
             watchdog_time);
    $display("Test failed");
    $finish;
end

initial
begin
    seed = 32'hc67ef400;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    mem_stall = 1'b0;
    stall_enable = 1'b0;
    stall_left = 0;
    main_checks = 0;
    main_errors = 0;
    mon_checks = 0;
    mon_errors = 0;
    tests_run = 0;
    current_test = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    run_reset_latency();
    run_stream("alu_ops", group_alu, n_alu, 1'b0);
    run_stream("address_forms", group_addr, n_addr, 1'b0);
    run_stream("branches", group_branch, n_branch, 1'b0);
    run_stream("back_pressure", group_all, n_stress, 1'b1);
    $display("%0d tests, %0d checks, %0d errors", tests_run,
             main_checks + mon_checks, main_errors + mon_errors);
    if (main_errors + mon_errors == 0)
        $display("Test completed successfully");
    else
        $display("Test failed");
    $finish;
end

endmodule : lc3b_pipe_tb

// ==== src/lc3b_pipe.sv ====
module lc3b_pipe
(
    input clk,
    input reset,

    input fetch_valid,
    input lc3b_types::fetch_packet fetch,
    input mem_stall,

    output logic fetch_stall,
    output logic mem_valid,
    output lc3b_types::mem_packet mem
);

import lc3b_types::*;

logic dec_valid;
decode_packet dec;
logic head_valid;
decode_packet head;
logic pop;

decode decode_inst
(
    .clk,
    .reset,
    .fetch_valid,
    .fetch,
    .stall(fetch_stall),
    .dec_valid,
    .dec
);

// the queue's full level doubles as the fetch stall.
stage_queue stage_queue_inst
(
    .clk,
    .reset,
    .in_valid(dec_valid),
    .in(dec),
    .full(fetch_stall),
    .pop,
    .head_valid,
    .head
);

execute execute_inst
(
    .clk,
    .reset,
    .head_valid,
    .head,
    .mem_stall,
    .pop,
    .mem_valid,
    .mem
);

endmodule : lc3b_pipe

// ==== src/execute.sv ====
module execute
(
    input clk,
    input reset,

    input head_valid,
    input lc3b_types::decode_packet head,
    input mem_stall,
    output logic pop,

    output logic mem_valid,
    output lc3b_types::mem_packet mem
);

import lc3b_types::*;

lc3b_control_word cw;
lc3b_instr ir;

lc3b_word addr1;
lc3b_word addr2;
lc3b_word offset;
lc3b_word address;
lc3b_word alu_b;
lc3b_word alu_f;
lc3b_word result;

lc3b_nzp cc;
lc3b_nzp cc_next;
logic br_taken;

assign cw = head.cw;
assign ir = head.instruction;

assign pop = head_valid && !mem_stall;

assign addr1 = (cw.addr1_sel == addr1_sr1) ? head.sr1_val : head.npc;

always_comb
begin
    case (cw.addr2_sel)
        addr2_off6:
            addr2 = {{10{ir.offset6_form.offset6[5]}}, ir.offset6_form.offset6};
        addr2_off9:
            addr2 = {{7{ir.pcoffset9_form.pcoffset9[8]}}, ir.pcoffset9_form.pcoffset9};
        default:
            addr2 = 16'h0000;
    endcase
end

assign offset = cw.lshf_enable ? {addr2[14:0], 1'b0} : addr2;

// jmp selects sr1 with a zero offset, so its target is the base itself.
assign address = addr1 + offset;

always_comb
begin
    case (cw.sr2_sel)
        sr2_imm5:
            alu_b = {{11{ir.imm_form.imm5[4]}}, ir.imm_form.imm5};
        sr2_amount4:
            alu_b = {12'h000, ir.shift_form.amount4};
        default:
            alu_b = head.sr2_val;
    endcase
end

alu alu_inst
(
    .aluop(cw.aluop),
    .a(head.sr1_val),
    .b(alu_b),
    .f(alu_f)
);

always_comb
begin
    if (cw.opcode == op_lea)
        result = address;
    else if (cw.mem_write)
        result = head.sr2_val;
    else
        result = alu_f;
end

always_comb
begin
    cc_next = cc;
    if (cw.load_cc)
    begin
        if (result[15])
            cc_next = 3'b100;
        else if (result == 16'h0000)
            cc_next = 3'b010;
        else
            cc_next = 3'b001;
    end
end

// jmp always redirects fetch.
assign br_taken = cw.is_jump || (cw.is_branch && ((ir.pcoffset9_form.nzp & cc) != 3'b000));

always_ff @(posedge clk)
begin
    if (reset)
        cc <= cc_reset;
    else if (pop)
        cc <= cc_next;
end

always_ff @(posedge clk)
begin
    if (reset)
        mem_valid <= 1'b0;
    else if (!mem_stall)
        mem_valid <= head_valid;
end

always_ff @(posedge clk)
begin
    if (pop)
    begin
        mem.opcode <= cw.opcode;
        mem.dr <= head.dr;
        mem.result <= result;
        mem.address <= address;
        mem.mem_read <= cw.mem_read;
        mem.mem_write <= cw.mem_write;
        mem.byte_access <= cw.byte_access;
        mem.br_taken <= br_taken;
        mem.cc <= cc_next;
    end
end

endmodule : execute

// ==== src/alu.sv ====
module alu
(
    input lc3b_types::lc3b_aluop aluop,
    input lc3b_types::lc3b_word a,
    input lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word f
);

import lc3b_types::*;

always_comb
begin
    case (aluop)
        alu_add:
            f = a + b;
        alu_and:
            f = a & b;
        alu_not:
            f = ~a;
        // shifts use only the low four bits of b.
        alu_sll:
            f = a << b[3:0];
        alu_srl:
            f = a >> b[3:0];
        alu_sra:
            f = lc3b_word'($signed(a) >>> b[3:0]);
        default:
            f = b;
    endcase
end

endmodule : alu

// ==== src/stage_queue.sv ====
module stage_queue
(
    input clk,
    input reset,

    input in_valid,
    input lc3b_types::decode_packet in,
    output logic full,

    input pop,
    output logic head_valid,
    output lc3b_types::decode_packet head
);

import lc3b_types::*;

decode_packet slots [queue_depth];
logic rd_ptr;
logic wr_ptr;
logic [1:0] count;
logic push;

// a pop on a full queue frees the slot for this edge's write.
assign full = (count == 2'(queue_depth)) && !pop;
assign push = in_valid && !full;

assign head_valid = (count != 2'd0);
assign head = slots[rd_ptr];

always_ff @(posedge clk)
begin
    if (push)
        slots[wr_ptr] <= in;
end

always_ff @(posedge clk)
begin
    if (reset)
    begin
        rd_ptr <= 1'b0;
        wr_ptr <= 1'b0;
        count <= 2'd0;
    end
    else
    begin
        if (push)
            wr_ptr <= wr_ptr + 1'b1;
        if (pop)
            rd_ptr <= rd_ptr + 1'b1;
        case ({push, pop})
            2'b10: count <= count + 2'd1;
            2'b01: count <= count - 2'd1;
            default: count <= count;
        endcase
    end
end

endmodule : stage_queue

// ==== src/decode.sv ====
module decode
(
    input clk,
    input reset,

    input fetch_valid,
    input lc3b_types::fetch_packet fetch,
    input stall,

    output logic dec_valid,
    output lc3b_types::decode_packet dec
);

import lc3b_types::*;

lc3b_instr ir;
lc3b_control_word cw;

assign ir = fetch.instruction;

always_comb
begin
    cw.opcode = ir.reg_form.opcode;
    cw.aluop = alu_pass;
    cw.load_cc = 1'b0;
    cw.mem_read = 1'b0;
    cw.mem_write = 1'b0;
    cw.byte_access = 1'b0;
    cw.addr1_sel = addr1_npc;
    cw.addr2_sel = addr2_zero;
    cw.lshf_enable = 1'b0;
    cw.sr2_sel = sr2_reg;
    cw.is_branch = 1'b0;
    cw.is_jump = 1'b0;

    case (ir.reg_form.opcode)
        op_add, op_and:
        begin
            cw.aluop = (ir.reg_form.opcode == op_add) ? alu_add : alu_and;
            cw.load_cc = 1'b1;
            if (ir.imm_form.imm_flag)
                cw.sr2_sel = sr2_imm5;
        end
        op_not:
        begin
            cw.aluop = alu_not;
            cw.load_cc = 1'b1;
        end
        op_shf:
        begin
            cw.load_cc = 1'b1;
            cw.sr2_sel = sr2_amount4;
            if (!ir.shift_form.dir[0])
                cw.aluop = alu_sll;
            else if (ir.shift_form.dir[1])
                cw.aluop = alu_sra;
            else
                cw.aluop = alu_srl;
        end
        op_lea:
        begin
            cw.load_cc = 1'b1;
            cw.addr2_sel = addr2_off9;
            cw.lshf_enable = 1'b1;
        end
        op_ldr, op_str, op_ldb, op_stb:
        begin
            cw.mem_read = (ir.reg_form.opcode == op_ldr) || (ir.reg_form.opcode == op_ldb);
            cw.mem_write = (ir.reg_form.opcode == op_str) || (ir.reg_form.opcode == op_stb);
            cw.byte_access = (ir.reg_form.opcode == op_ldb) || (ir.reg_form.opcode == op_stb);
            cw.addr1_sel = addr1_sr1;
            cw.addr2_sel = addr2_off6;
            // word accesses scale the offset, byte accesses do not.
            cw.lshf_enable = !cw.byte_access;
        end
        op_br:
        begin
            cw.is_branch = 1'b1;
            cw.addr2_sel = addr2_off9;
            cw.lshf_enable = 1'b1;
        end
        op_jmp:
        begin
            cw.is_jump = 1'b1;
            cw.addr1_sel = addr1_sr1;
        end
        default:
        begin
            // unsupported encodings pass through as a no-op.
            cw.aluop = alu_pass;
        end
    endcase
end

always_ff @(posedge clk)
begin
    if (reset)
        dec_valid <= 1'b0;
    else if (!stall)
        dec_valid <= fetch_valid;
end

always_ff @(posedge clk)
begin
    if (!stall)
    begin
        dec.cw <= cw;
        dec.npc <= fetch.npc;
        dec.instruction <= fetch.instruction;
        dec.sr1_val <= fetch.sr1_val;
        dec.sr2_val <= fetch.sr2_val;
        dec.dr <= ir.reg_form.dr;
    end
end

endmodule : decode

// ==== src/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// condition codes after reset read zero.
localparam lc3b_nzp cc_reset = 3'b010;
localparam int queue_depth = 2;

typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_ldb = 4'b0010,
    op_stb = 4'b0011,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001,
    op_jmp = 4'b1100,
    op_shf = 4'b1101,
    op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [2:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass,
    alu_sll,
    alu_srl,
    alu_sra
} lc3b_aluop;

typedef enum logic {
    addr1_npc,
    addr1_sr1
} lc3b_addr1_sel;

typedef enum logic [1:0] {
    addr2_zero,
    addr2_off6,
    addr2_off9
} lc3b_addr2_sel;

typedef enum logic [1:0] {
    sr2_reg,
    sr2_imm5,
    sr2_amount4
} lc3b_sr2_sel;

// one instruction word, read in whichever format its opcode implies.
typedef union packed {
    struct packed {
        lc3b_opcode opcode;
        lc3b_reg dr;
        lc3b_reg sr1;
        logic imm_flag;
        logic [1:0] unused;
        lc3b_reg sr2;
    } reg_form;
    struct packed {
        lc3b_opcode opcode;
        lc3b_reg dr;
        lc3b_reg sr1;
        logic imm_flag;
        logic [4:0] imm5;
    } imm_form;
    struct packed {
        lc3b_opcode opcode;
        lc3b_reg dr;
        lc3b_reg sr1;
        // bit 1 arithmetic, bit 0 right.
        logic [1:0] dir;
        logic [3:0] amount4;
    } shift_form;
    struct packed {
        lc3b_opcode opcode;
        lc3b_reg dr;
        lc3b_reg base;
        logic [5:0] offset6;
    } offset6_form;
    struct packed {
        lc3b_opcode opcode;
        lc3b_nzp nzp;
        logic [8:0] pcoffset9;
    } pcoffset9_form;
} lc3b_instr;

typedef struct packed {
    lc3b_opcode opcode;
    lc3b_aluop aluop;
    logic load_cc;
    logic mem_read;
    logic mem_write;
    logic byte_access;
    lc3b_addr1_sel addr1_sel;
    lc3b_addr2_sel addr2_sel;
    logic lshf_enable;
    lc3b_sr2_sel sr2_sel;
    logic is_branch;
    logic is_jump;
} lc3b_control_word;

typedef struct packed {
    lc3b_word npc;
    lc3b_instr instruction;
    lc3b_word sr1_val;
    lc3b_word sr2_val;
} fetch_packet;

typedef struct packed {
    lc3b_control_word cw;
    lc3b_word npc;
    lc3b_instr instruction;
    lc3b_word sr1_val;
    lc3b_word sr2_val;
    lc3b_reg dr;
} decode_packet;

typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg dr;
    lc3b_word result;
    lc3b_word address;
    logic mem_read;
    logic mem_write;
    logic byte_access;
    logic br_taken;
    lc3b_nzp cc;
} mem_packet;

endpackage : lc3b_types
